// ==== all.f ====
src/rrelu_pkg.sv
src/lfsr_step.sv
src/rrelu_lane.sv
src/rrelu_config.sv
src/fixed_rrelu.sv
src/rrelu_top.sv
sim/tb_rrelu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the RReLU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_rrelu -f all.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_rrelu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== sim/tb_rrelu.sv ====
`timescale 1ns/1ps

module tb_rrelu
  import rrelu_pkg::*;
();

  localparam int lanes          = default_lanes;
  localparam int num_samples    = 160;
  localparam int run_cycles     = 6 * num_samples + 40;   // All phases, back-pressure twice
  localparam int timeout_cycles = 2 * run_cycles;

  logic        clk;
  logic        rst;
  data_t       data_in [lanes];
  logic        in_valid;
  logic        in_ready;
  data_t       data_out [lanes];
  logic        out_valid;
  logic        out_ready;
  logic        cfg_write;
  reg_addr_e   cfg_addr;
  logic [15:0] cfg_wdata;

  // Model of the register block and the lane LFSRs
  logic        model_train;
  slope_t      model_fixed;
  slope_t      model_mask;
  seed_t       model_state [lanes];

  logic [31:0] lcg_state;
  int          cycle_count = 0;
  logic        stalled = 1'b0;
  data_t       held_out [lanes];

  rrelu_top #(
    .lanes (lanes)
  ) rrelu_top_i (
    .clk       (clk),
    .rst       (rst),
    .data_in   (data_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .data_out  (data_out),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ##########################################################################
  // Reference model
  // ##########################################################################

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic seed_t lfsr_next(input seed_t s);
    if (s[15])
      return {s[14:0], 1'b0} ^ default_lfsr_poly;
    return {s[14:0], 1'b0};
  endfunction

  function automatic seed_t salted_start(input seed_t s, input int lane);
    seed_t v;
    v = s ^ seed_t'(lane);
    return (v == 16'h0000) ? 16'hFFFF : v;
  endfunction

  // Bit b kept when 2^b is below 256 >> upper but not below 256 >> lower
  function automatic slope_t mask_for(input shift_t upper, input shift_t lower);
    slope_t m;
    m = '0;
    for (int b = 0; b < 8; b++)
    begin
      if (((1 << b) < (256 >> upper)) && !((1 << b) < (256 >> lower)))
        m[b] = 1'b1;
    end
    return m;
  endfunction

  function automatic data_t expected_lane(input data_t x, input seed_t state,
                                          input logic train, input slope_t fixed,
                                          input slope_t mask);
    slope_t s;
    longint p;
    if (x >= 0)
      return x;
    s = train ? (state[7:0] & mask) : fixed;
    p = longint'(x) * longint'(s);
    return data_t'(p >>> 8);   // Arithmetic shift, then keep 16 bits
  endfunction

  // ##########################################################################
  // Checks
  // ##########################################################################

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input int lane,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t: %s lane %0d, got %h expected %h",
                          $time, what, lane, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp));
  endtask

  always @(posedge clk)
  begin
    data_t expected;
    if (!rst)
    begin
      check_bit(out_valid, in_valid, "out_valid");
      check_bit(in_ready, out_ready, "in_ready");
    end
    if (!rst && in_valid)
    begin
      for (int k = 0; k < lanes; k++)
      begin
        expected = expected_lane(data_in[k], model_state[k], model_train,
                                 model_fixed, model_mask);
        check_data(data_out[k], expected, k, "data_out");
        if (stalled)
          check_data(data_out[k], held_out[k], k, "held output");   // Same sample
      end
      stalled = !out_ready;
      held_out = data_out;
      if (out_ready && model_train)
      begin
        for (int k = 0; k < lanes; k++)
          model_state[k] = lfsr_next(model_state[k]);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
      abort_run($sformatf("Timeout: the run did not end within %0d cycles", timeout_cycles));
  end

  // ##########################################################################
  // Stimulus
  // ##########################################################################

  task automatic write_reg(input reg_addr_e addr, input logic [15:0] value);
    @(negedge clk);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = value;
    @(negedge clk);
    cfg_write = 1'b0;
    case (addr)
      reg_mode:  model_train = value[0];
      reg_slope: model_fixed = value[7:0];
      reg_range: model_mask = mask_for(value[3:0], value[7:4]);
      reg_seed:
      begin
        @(negedge clk);   // Lanes reload at the end of the reseed cycle
        for (int k = 0; k < lanes; k++)
          model_state[k] = salted_start(value, k);
      end
    endcase
  endtask

  // Producer keeps its sample until it is taken
  task automatic stream_samples(input int count, input bit random_ready);
    int          sent;
    bit          take_new;
    logic [15:0] ready_draw;
    sent = 0;
    take_new = 1'b1;
    while (sent < count)
    begin
      @(negedge clk);
      if (take_new)
      begin
        for (int k = 0; k < lanes; k++)
          data_in[k] = data_t'(next_random());
      end
      in_valid = 1'b1;
      if (random_ready)
      begin
        ready_draw = next_random();
        out_ready  = ready_draw[7];
      end
      else
      begin
        out_ready = 1'b1;
      end
      take_new = out_ready;
      if (out_ready)
        sent++;
    end
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
  endtask

  initial
  begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    cfg_write = 1'b0;
    cfg_addr  = reg_mode;
    cfg_wdata = '0;
    for (int k = 0; k < lanes; k++)
    begin
      data_in[k]     = '0;
      held_out[k]    = '0;
      model_state[k] = salted_start(16'hFFFF, k);
    end
    lcg_state   = 32'd97197;
    model_train = 1'b1;
    model_fixed = 8'h20;
    model_mask  = mask_for(4'd1, 4'd6);

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;   // Reseed cycle follows with in_valid low

    // Training mode with reset defaults
    stream_samples(num_samples, 1'b0);

    // Evaluation mode with a fixed slope
    write_reg(reg_mode, 16'h0000);
    write_reg(reg_slope, 16'h0033);
    stream_samples(num_samples, 1'b0);

    // Back to training, narrower range
    write_reg(reg_mode, 16'h0001);
    write_reg(reg_range, 16'h0042);
    stream_samples(num_samples, 1'b0);

    // Fresh seed
    write_reg(reg_seed, 16'hACE1);
    stream_samples(num_samples, 1'b0);

    // Zero seed on lane 0, full range, random back-pressure
    write_reg(reg_seed, 16'h0000);
    write_reg(reg_range, 16'h0080);
    stream_samples(num_samples, 1'b1);

    repeat (2) @(negedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== src/fixed_rrelu.sv ====
`timescale 1ns/1ps

module fixed_rrelu
  import rrelu_pkg::*;
#(
  parameter int    lanes     = default_lanes,
  parameter seed_t lfsr_poly = default_lfsr_poly
) (
  input  logic   clk,
  input  logic   rst,

  input  data_t  data_in [lanes],
  input  logic   in_valid,
  output logic   in_ready,

  output data_t  data_out [lanes],
  output logic   out_valid,
  input  logic   out_ready,

  input  logic   train_mode,
  input  slope_t fixed_slope,
  input  slope_t slope_mask,
  input  seed_t  seed,
  input  logic   reseed
);

  logic transfer;
  logic advance;

  // Zero latency handshake
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  // Random slopes only move on an accepted sample
  assign transfer = in_valid && out_ready;
  assign advance  = transfer && train_mode;

  // ##########################################################################
  // Lanes
  // ##########################################################################

  for (genvar i = 0; i < lanes; i++)
  begin : g_lane
    rrelu_lane #(
      .lane_index (i),
      .lfsr_poly  (lfsr_poly)
    ) rrelu_lane_i (
      .clk         (clk),
      .rst         (rst),
      .advance     (advance),
      .reseed      (reseed),
      .train_mode  (train_mode),
      .fixed_slope (fixed_slope),
      .slope_mask  (slope_mask),
      .seed        (seed),
      .sample_in   (data_in[i]),
      .sample_out  (data_out[i])
    );
  end

endmodule

// ==== src/lfsr_step.sv ====
`timescale 1ns/1ps

// One step of a Galois LFSR, left shifting
module lfsr_step
  import rrelu_pkg::*;
#(
  parameter seed_t lfsr_poly = default_lfsr_poly
) (
  input  seed_t state_in,
  output seed_t state_out
);

  logic  feedback;
  seed_t shifted;

  assign feedback = state_in[$bits(seed_t)-1];   // Bit falling off the top
  assign shifted  = {state_in[$bits(seed_t)-2:0], 1'b0};

  always_comb
  begin
    if (feedback)
    begin
      state_out = shifted ^ lfsr_poly;
    end
    else
    begin
      state_out = shifted;
    end
  end

endmodule

// ==== src/rrelu_config.sv ====
`timescale 1ns/1ps

module rrelu_config
  import rrelu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_write,
  input  reg_addr_e   cfg_addr,
  input  logic [15:0] cfg_wdata,
  output logic        train_mode,
  output slope_t      fixed_slope,
  output slope_t      slope_mask,
  output seed_t       seed,
  output logic        reseed
);

  shift_t upper_shift;
  shift_t lower_shift;
  slope_t upper_bits;
  slope_t lower_bits;

  // Slope bits below 2^frac_width >> shift
  function automatic slope_t bits_below(input shift_t shift);
    logic [frac_width:0] limit;
    limit = {1'b1, {frac_width{1'b0}}} >> shift;
    if (limit == '0)
      return '0;
    return slope_t'(limit - 1'b1);
  endfunction

  // ##########################################################################
  // Registers
  // ##########################################################################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      train_mode  <= default_train_mode;
      fixed_slope <= default_fixed_slope;
      upper_shift <= default_upper;
      lower_shift <= default_lower;
      seed        <= default_seed;
    end
    else if (cfg_write)
    begin
      case (cfg_addr)
        reg_mode:  train_mode <= cfg_wdata[0];
        reg_slope: fixed_slope <= cfg_wdata[frac_width-1:0];
        reg_range:
        begin
          upper_shift <= cfg_wdata[3:0];
          lower_shift <= cfg_wdata[7:4];
        end
        reg_seed:  seed <= cfg_wdata;
      endcase
    end
  end

  // Lanes reload in the cycle after reset or a seed write
  always_ff @(posedge clk)
  begin
    if (rst)
      reseed <= 1'b1;
    else
      reseed <= cfg_write && (cfg_addr == reg_seed);
  end

  // Mask keeps bits between the upper and lower limits
  assign upper_bits = bits_below(upper_shift);
  assign lower_bits = bits_below(lower_shift);
  assign slope_mask = upper_bits & ~lower_bits;

endmodule

// ==== src/rrelu_lane.sv ====
`timescale 1ns/1ps

module rrelu_lane
  import rrelu_pkg::*;
#(
  parameter int    lane_index = 0,
  parameter seed_t lfsr_poly  = default_lfsr_poly
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   advance,       // Transfer in training mode
  input  logic   reseed,
  input  logic   train_mode,
  input  slope_t fixed_slope,
  input  slope_t slope_mask,
  input  seed_t  seed,
  input  data_t  sample_in,
  output data_t  sample_out
);

  seed_t  salted_seed;
  seed_t  start_state;
  seed_t  state;
  seed_t  next_state;
  slope_t lfsr_slope;
  slope_t slope;

  // Full product of Q8.8 sample and 0.8 slope
  logic signed [data_width+frac_width:0] product;
  logic signed [data_width+frac_width:0] scaled;

  // ##########################################################################
  // Random slope source
  // ##########################################################################

  // Each lane starts from its own point in the sequence
  assign salted_seed = seed ^ seed_t'(lane_index);
  assign start_state = (salted_seed == '0) ? '1 : salted_seed;   // Zero locks up

  always_ff @(posedge clk)
  begin
    if (rst || reseed)
    begin
      state <= start_state;
    end
    else if (advance)
    begin
      state <= next_state;
    end
  end

  lfsr_step #(
    .lfsr_poly (lfsr_poly)
  ) lfsr_step_i (
    .state_in  (state),
    .state_out (next_state)
  );

  // Slope taken from the state before this cycle's step
  assign lfsr_slope = state[frac_width-1:0] & slope_mask;
  assign slope      = train_mode ? lfsr_slope : fixed_slope;

  // ##########################################################################
  // Scaling of negative samples
  // ##########################################################################

  assign product = sample_in * $signed({1'b0, slope});   // Slope is never negative
  assign scaled  = product >>> frac_width;               // Back to Q8.8

  always_comb
  begin
    if (sample_in < 0)
    begin
      sample_out = scaled[data_width-1:0];
    end
    else
    begin
      sample_out = sample_in;
    end
  end

endmodule

// ==== src/rrelu_pkg.sv ====
package rrelu_pkg;

  // ##########################################################################
  // Q8.8 sample format
  // ##########################################################################

  localparam int data_width = 16;
  localparam int frac_width = 8;   // Fraction bits, also the slope width

  typedef logic signed [data_width-1:0] data_t;
  typedef logic [frac_width-1:0] slope_t;   // Value is slope / 256
  typedef logic [15:0] seed_t;              // LFSR state word
  typedef logic [3:0] shift_t;              // Range field, one nibble each

  // Register map
  typedef enum logic [1:0] {
    reg_mode  = 2'd0,
    reg_slope = 2'd1,
    reg_range = 2'd2,
    reg_seed  = 2'd3
  } reg_addr_e;

  localparam int    default_lanes     = 4;
  localparam seed_t default_lfsr_poly = 16'h1021;   // CRC-16 CCITT

  // ##########################################################################
  // Register reset values
  // ##########################################################################

  localparam logic   default_train_mode  = 1'b1;
  localparam slope_t default_fixed_slope = 8'h20;   // 1/8
  localparam shift_t default_upper       = 4'd1;    // Slopes below 1/2
  localparam shift_t default_lower       = 4'd6;    // Down to 1/64

  // Mask 0x7C with the shifts above
  localparam seed_t  default_seed        = '1;

endpackage

// ==== src/rrelu_top.sv ====
`timescale 1ns/1ps

module rrelu_top
  import rrelu_pkg::*;
#(
  parameter int    lanes     = default_lanes,
  parameter seed_t lfsr_poly = default_lfsr_poly
) (
  input  logic        clk,
  input  logic        rst,

  // Sample stream
  input  data_t       data_in [lanes],
  input  logic        in_valid,
  output logic        in_ready,
  output data_t       data_out [lanes],
  output logic        out_valid,
  input  logic        out_ready,

  // Host register writes
  input  logic        cfg_write,
  input  reg_addr_e   cfg_addr,
  input  logic [15:0] cfg_wdata
);

  logic   train_mode;
  slope_t fixed_slope;
  slope_t slope_mask;
  seed_t  seed;
  logic   reseed;

  rrelu_config rrelu_config_i (
    .clk         (clk),
    .rst         (rst),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .train_mode  (train_mode),
    .fixed_slope (fixed_slope),
    .slope_mask  (slope_mask),
    .seed        (seed),
    .reseed      (reseed)
  );

  fixed_rrelu #(
    .lanes     (lanes),
    .lfsr_poly (lfsr_poly)
  ) fixed_rrelu_i (
    .clk         (clk),
    .rst         (rst),
    .data_in     (data_in),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .data_out    (data_out),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .train_mode  (train_mode),
    .fixed_slope (fixed_slope),
    .slope_mask  (slope_mask),
    .seed        (seed),
    .reseed      (reseed)
  );

endmodule
